// File: include/soc_defs.svh
// Bus widths, region pages and CLINT offsets; mtime and mtimecmp are one 32-bit word each
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////
`define SOC_DATA_W 32
`define SOC_ADDR_W 32
`define SOC_BE_W   4

// Address split, page on top
`define SOC_PAGE_W 16
`define SOC_OFFS_W 16

//////////////////////////////
// Memory map
//////////////////////////////
`define ROM_PAGE   16'h0001
`define CLINT_PAGE 16'h0200
`define MEM_PAGE   16'h8000

// Depths in 32-bit words
`define ROM_WORDS 16
`define MEM_WORDS 128

// CLINT register offsets inside its page
`define CLINT_MSIP_OFFS     16'h0000
`define CLINT_MTIMECMP_OFFS 16'h4000
`define CLINT_MTIME_OFFS    16'hBFF8

// ROM word i is the signature with i in the low byte
`define ROM_SIGNATURE 32'h6F00_0000

// Read data on every error response
`define BUS_ERR_DATA 32'hDEAD_BEEF

`endif

// File: logic/soc_bus_pkg.sv
// Bus transfer types; one word per access, byte enables apply to writes only
`include "soc_defs.svh"

package soc_bus_pkg;

  //////////////////////////////
  // Address views
  //////////////////////////////

  // Page selects the target, offset goes to the target
  typedef struct packed {
    logic [`SOC_PAGE_W-1:0] page;
    logic [`SOC_OFFS_W-1:0] offset;
  } bus_page_addr_t;

  // Same word, flat for the master, split for the decoder
  typedef union packed {
    logic [`SOC_ADDR_W-1:0] flat;
    bus_page_addr_t         pg;
  } bus_addr_u;

  //////////////////////////////
  // Master side
  //////////////////////////////
  typedef struct packed {
    logic                   we;
    bus_addr_u              addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

  // Target side, en is a single-cycle strobe
  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_OFFS_W-1:0] offset;
    logic [`SOC_DATA_W-1:0] wdata;
  } tgt_access_t;

  // Merge write data into a word, lane by lane
  function automatic logic [`SOC_DATA_W-1:0] be_merge(
    input logic [`SOC_DATA_W-1:0] old_data,
    input logic [`SOC_DATA_W-1:0] new_data,
    input logic [`SOC_BE_W-1:0]   be
  );
    logic [`SOC_DATA_W-1:0] merged;
    merged = old_data;
    for (int b = 0; b < `SOC_BE_W; b++)
    begin
      if (be[b])
      begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: logic/soc_map_pkg.sv
// Memory map types; only ROM, main memory and CLINT are mapped, all else decodes to none
package soc_map_pkg;

  //////////////////////////////
  // Regions
  //////////////////////////////

  // Result of the page decode
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_MEM,
    REGION_CLINT,
    REGION_NONE
  } region_e;

  //////////////////////////////
  // Target select
  //////////////////////////////

  // One-hot, at most one bit set
  // All zero on a decode error
  typedef struct packed {
    logic clint;
    logic mem;
    logic rom;
  } tgt_sel_t;

endpackage

// File: logic/bus_ctrl.sv
// Four-phase req/ack bus controller; one access at a time, ack 2 edges after req, no timeout
`timescale 1ns/10ps
`include "soc_defs.svh"

module bus_ctrl (
  input  logic                     clk,
  input  logic                     ndmreset_n,
  input  logic                     req_i,
  input  soc_bus_pkg::bus_req_t    bus_req_i,
  output logic                     ack_o,
  output soc_bus_pkg::bus_rsp_t    bus_rsp_o,
  output soc_bus_pkg::tgt_access_t rom_acc_o,
  output soc_bus_pkg::tgt_access_t mem_acc_o,
  output soc_bus_pkg::tgt_access_t clint_acc_o,
  input  logic [`SOC_DATA_W-1:0]   rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0]   mem_rdata_i,
  input  logic [`SOC_DATA_W-1:0]   clint_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_RESPOND, ST_WAIT_REL} state_e;

  state_e                 state_q, state_d;
  region_e                region;
  tgt_sel_t               sel, sel_q;
  logic                   dec_err, err_q, we_q;
  tgt_access_t            acc;
  logic [`SOC_DATA_W-1:0] rdata_mux;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb
  begin
    case (bus_req_i.addr.pg.page)
      `ROM_PAGE:   region = REGION_ROM;
      `MEM_PAGE:   region = REGION_MEM;
      `CLINT_PAGE: region = REGION_CLINT;
      default:     region = REGION_NONE;
    endcase
  end

  // Unmapped page, or store into ROM
  assign dec_err = (region == REGION_NONE) || ((region == REGION_ROM) && bus_req_i.we);

  always_comb
  begin
    sel       = '0;
    sel.rom   = (region == REGION_ROM) && !dec_err;
    sel.mem   = (region == REGION_MEM);
    sel.clint = (region == REGION_CLINT);
  end

  // Shared access word, en only in the issue cycle
  always_comb
  begin
    acc.en      = (state_q == ST_ISSUE) && !dec_err;
    acc.we      = bus_req_i.we;
    acc.be      = bus_req_i.be;
    acc.offset  = bus_req_i.addr.pg.offset;
    acc.wdata   = bus_req_i.wdata;
    rom_acc_o   = acc;
    mem_acc_o   = acc;
    clint_acc_o = acc;
    rom_acc_o.en   = acc.en && sel.rom;
    mem_acc_o.en   = acc.en && sel.mem;
    clint_acc_o.en = acc.en && sel.clint;
  end

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:     if (req_i) state_d = ST_ISSUE;
      ST_ISSUE:    state_d = ST_RESPOND;
      ST_RESPOND:  state_d = ST_WAIT_REL;
      ST_WAIT_REL: if (!req_i) state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge ndmreset_n)
  begin
    if (!ndmreset_n)
    begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Remember target for the data a cycle later
      if (state_q == ST_ISSUE)
      begin
        sel_q <= sel;
        err_q <= dec_err;
        we_q  <= bus_req_i.we;
      end
    end
  end

  // Ack held until the master lets go
  assign ack_o = (state_q == ST_WAIT_REL);

  //////////////////////////////
  // Response capture
  //////////////////////////////
  assign rdata_mux = ({`SOC_DATA_W{sel_q.rom}}   & rom_rdata_i)
                   | ({`SOC_DATA_W{sel_q.mem}}   & mem_rdata_i)
                   | ({`SOC_DATA_W{sel_q.clint}} & clint_rdata_i);

  // Writes answer with zero data
  always_ff @(posedge clk)
  begin
    if (state_q == ST_RESPOND)
    begin
      bus_rsp_o.err   <= err_q;
      bus_rsp_o.rdata <= err_q ? `BUS_ERR_DATA : (we_q ? '0 : rdata_mux);
    end
  end

endmodule

// File: logic/boot_rom.sv
// Boot ROM of ROM_WORDS words from the signature rule; reads only, index past the table reads 0
`timescale 1ns/10ps
`include "soc_defs.svh"

module boot_rom (
  input  logic                     clk,
  input  soc_bus_pkg::tgt_access_t acc_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o
);

  localparam int ROM_IDX_W = $clog2(`ROM_WORDS);

  logic [`SOC_DATA_W-1:0] rom_table [`ROM_WORDS];
  logic [`SOC_OFFS_W-3:0] word_idx;

  //////////////////////////////
  // Table contents
  //////////////////////////////

  // Signature with the word index in the low byte
  for (genvar i = 0; i < `ROM_WORDS; i++)
  begin : g_rom_word
    assign rom_table[i] = (`ROM_SIGNATURE & 32'hFFFF_FF00) | `SOC_DATA_W'(i);
  end

  // Word address, byte bits dropped
  assign word_idx = acc_i.offset[`SOC_OFFS_W-1:2];

  //////////////////////////////
  // Registered read
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (acc_i.en && !acc_i.we)
    begin
      if (word_idx < `ROM_WORDS)
      begin
        rdata_o <= rom_table[word_idx[ROM_IDX_W-1:0]];
      end
      else
      begin
        // Past the end of the table
        rdata_o <= '0;
      end
    end
  end

endmodule

// File: logic/main_mem.sv
// MEM_WORDS x 32-bit single-port RAM; offset bits above the word index alias, contents not reset
`timescale 1ns/10ps
`include "soc_defs.svh"

module main_mem (
  input  logic                     clk,
  input  soc_bus_pkg::tgt_access_t acc_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o
);
  import soc_bus_pkg::*;

  localparam int MEM_IDX_W = $clog2(`MEM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`MEM_WORDS];
  logic [MEM_IDX_W-1:0]   word_idx;

  // Word index from offset, byte lanes dropped
  assign word_idx = acc_i.offset[MEM_IDX_W+1:2];

  //////////////////////////////
  // Write port
  //////////////////////////////

  // Each lane under its own byte enable
  always_ff @(posedge clk)
  begin
    if (acc_i.en && acc_i.we)
    begin
      mem[word_idx] <= be_merge(mem[word_idx], acc_i.wdata, acc_i.be);
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // One cycle latency, held between reads
  always_ff @(posedge clk)
  begin
    if (acc_i.en && !acc_i.we)
    begin
      rdata_o <= mem[word_idx];
    end
  end

endmodule

// File: logic/clint_timer.sv
// CLINT with 32-bit mtime and mtimecmp, no upper halves; mtime wraps, rtc is clk divided by 2
`timescale 1ns/10ps
`include "soc_defs.svh"

module clint_timer (
  input  logic                     clk,
  input  logic                     ndmreset_n,
  input  soc_bus_pkg::tgt_access_t acc_i,
  output logic [`SOC_DATA_W-1:0]   rdata_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o
);
  import soc_bus_pkg::*;

  logic                   rtc;
  logic [`SOC_DATA_W-1:0] mtime, mtimecmp;
  logic                   msip;
  logic                   wr_en, wr_msip, wr_cmp, wr_mtime;

  //////////////////////////////
  // Write decode
  //////////////////////////////
  assign wr_en    = acc_i.en && acc_i.we;
  assign wr_msip  = wr_en && (acc_i.offset == `CLINT_MSIP_OFFS);
  assign wr_cmp   = wr_en && (acc_i.offset == `CLINT_MTIMECMP_OFFS);
  assign wr_mtime = wr_en && (acc_i.offset == `CLINT_MTIME_OFFS);

  // Real-time tick, half the clock rate
  always_ff @(posedge clk or negedge ndmreset_n)
  begin
    if (!ndmreset_n)
    begin
      rtc <= 1'b0;
    end
    else
    begin
      rtc <= ~rtc;
    end
  end

  //////////////////////////////
  // Timer registers
  //////////////////////////////
  always_ff @(posedge clk or negedge ndmreset_n)
  begin
    if (!ndmreset_n)
    begin
      mtime    <= '0;
      mtimecmp <= '1;
      msip     <= 1'b0;
    end
    else
    begin
      // Bus write wins over the tick
      if (wr_mtime)
        mtime <= be_merge(mtime, acc_i.wdata, acc_i.be);
      else if (rtc)
        mtime <= mtime + 1'b1;
      if (wr_cmp)
        mtimecmp <= be_merge(mtimecmp, acc_i.wdata, acc_i.be);
      // Only bit 0 of msip exists
      if (wr_msip && acc_i.be[0])
        msip <= acc_i.wdata[0];
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (acc_i.en && !acc_i.we)
    begin
      case (acc_i.offset)
        `CLINT_MSIP_OFFS:     rdata_o <= {{(`SOC_DATA_W-1){1'b0}}, msip};
        `CLINT_MTIMECMP_OFFS: rdata_o <= mtimecmp;
        `CLINT_MTIME_OFFS:    rdata_o <= mtime;
        default:              rdata_o <= '0;
      endcase
    end
  end

  // Level interrupts
  assign timer_irq_o = (mtime >= mtimecmp);
  assign ipi_o       = msip;

endmodule

// File: logic/soc_top.sv
// SoC skeleton top; one bus master port, ndmreset_n used directly with no synchronizer
`timescale 1ns/10ps
`include "soc_defs.svh"

module soc_top (
  input  logic                  clk,
  input  logic                  ndmreset_n,
  input  logic                  req_i,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output logic                  ack_o,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output logic                  timer_irq_o,
  output logic                  ipi_o
);
  import soc_bus_pkg::*;

  // Controller to targets
  tgt_access_t            rom_acc, mem_acc, clint_acc;
  // Targets back to controller
  logic [`SOC_DATA_W-1:0] rom_rdata, mem_rdata, clint_rdata;

  //////////////////////////////
  // Bus controller
  //////////////////////////////
  bus_ctrl i_bus_ctrl (
    .clk           ( clk         ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .bus_req_i     ( bus_req_i   ),
    .ack_o         ( ack_o       ),
    .bus_rsp_o     ( bus_rsp_o   ),
    .rom_acc_o     ( rom_acc     ),
    .mem_acc_o     ( mem_acc     ),
    .clint_acc_o   ( clint_acc   ),
    .rom_rdata_i   ( rom_rdata   ),
    .mem_rdata_i   ( mem_rdata   ),
    .clint_rdata_i ( clint_rdata )
  );

  //////////////////////////////
  // Targets
  //////////////////////////////
  boot_rom i_boot_rom (
    .clk     ( clk       ),
    .acc_i   ( rom_acc   ),
    .rdata_o ( rom_rdata )
  );

  main_mem i_main_mem (
    .clk     ( clk       ),
    .acc_i   ( mem_acc   ),
    .rdata_o ( mem_rdata )
  );

  // Interrupts go straight out
  clint_timer i_clint_timer (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .acc_i       ( clint_acc   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

// File: tb/tb_clk_gen.sv
// Free-running 10 ns clock; reset held low for the first 16 rising edges, then released for good
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic ndmreset_n_o
);

  localparam int RESET_CYCLES = 16;

  // 100 MHz clock starting low
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release lands on a rising edge
  initial
  begin
    ndmreset_n_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    ndmreset_n_o <= 1'b1;
  end

endmodule

// File: tb/tb_soc_top.sv
// Single-master testbench; assumes one access at a time and mtime counting from 0 after reset
`timescale 1ns/10ps
`include "soc_defs.svh"

module tb_soc_top;
  import soc_bus_pkg::*;

  localparam int TABLE_DEPTH = 40;
  localparam int WDOG_CYCLES = TABLE_DEPTH * 10 + 2000;
  localparam int ACK_LIMIT   = 16;
  localparam int IRQ_LIMIT   = 200;
  // Byte-enable mix for the partial writes with one nibble per write
  localparam logic [31:0] BE_MIX = 32'hA5C3_8421;
  localparam int ROM_IDX [5] = '{0, 1, 7, 15, 16};

  localparam logic [2:0] GRP_ROM   = 3'd1;
  localparam logic [2:0] GRP_MEM   = 3'd2;
  localparam logic [2:0] GRP_ERR   = 3'd3;
  localparam logic [2:0] GRP_MSIP  = 3'd4;
  localparam logic [2:0] GRP_TIMER = 3'd5;

  // One table row with its expected response
  typedef struct packed {
    logic [2:0]  grp;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        exp_ipi;
  } tb_entry_t;

  logic        clk, ndmreset_n, req, ack, timer_irq, ipi;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  tb_entry_t   table_e [TABLE_DEPTH];
  int          n_entries = 0;
  logic [31:0] mem_model [`MEM_WORDS];
  logic        ipi_model = 1'b0;
  logic [31:0] rand_state = 32'hea470c4e;
  int          checks = 0, errors = 0, tests_run = 0, tests_bad = 0;

  tb_clk_gen clk_gen0 (
    .clk_o        ( clk        ),
    .ndmreset_n_o ( ndmreset_n )
  );

  soc_top dut0 (
    .clk         ( clk        ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req        ),
    .bus_req_i   ( bus_req    ),
    .ack_o       ( ack        ),
    .bus_rsp_o   ( bus_rsp    ),
    .timer_irq_o ( timer_irq  ),
    .ipi_o       ( ipi        )
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Per-byte model of a write
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic [31:0] word_addr(input logic [15:0] page, input int idx);
    logic [15:0] offs;
    offs = 16'(idx * 4);
    return {page, offs};
  endfunction

  function automatic string group_name(input logic [2:0] grp);
    case (grp)
      GRP_ROM:  return "rom_read";
      GRP_MEM:  return "mem_rw";
      GRP_ERR:  return "bus_error";
      GRP_MSIP: return "msip";
      default:  return "unknown";
    endcase
  endfunction

  function automatic tb_entry_t make_entry(input logic [2:0] grp, input logic we,
                                           input logic [31:0] addr, input logic [3:0] be,
                                           input logic [31:0] wdata,
                                           input logic [31:0] exp_rdata, input logic exp_err);
    tb_entry_t ent;
    ent.grp       = grp;
    ent.we        = we;
    ent.addr      = addr;
    ent.be        = be;
    ent.wdata     = wdata;
    ent.exp_rdata = exp_rdata;
    ent.exp_err   = exp_err;
    ent.exp_ipi   = ipi_model;
    return ent;
  endfunction

  task automatic add_entry(input logic [2:0] grp, input logic we, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err);
    if (n_entries < TABLE_DEPTH)
    begin
      table_e[n_entries] = make_entry(grp, we, addr, be, wdata, exp_rdata, exp_err);
      n_entries++;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors > errs_before)
    begin
      tests_bad++;
      $display("Test %s: FAIL, %0d errors", name, errors - errs_before);
    end
    else
      $display("Test %s: ok", name);
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic build_table();
    int          idx;
    logic [31:0] wdata;
    logic [31:0] sig;
    logic [3:0]  be;
    sig = `ROM_SIGNATURE;
    // ROM reads with the last index one past the table
    for (int k = 0; k < 5; k++)
    begin
      if (ROM_IDX[k] < `ROM_WORDS)
        add_entry(GRP_ROM, 1'b0, word_addr(`ROM_PAGE, ROM_IDX[k]), 4'hF, '0,
                  {sig[31:8], 8'(ROM_IDX[k])}, 1'b0);
      else
        add_entry(GRP_ROM, 1'b0, word_addr(`ROM_PAGE, ROM_IDX[k]), 4'hF, '0, '0, 1'b0);
    end
    // Full words first so every lane is known and then mixed lanes
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int k = 0; k < 8; k++)
      begin
        idx   = (k * 17) % `MEM_WORDS;
        wdata = lcg_next();
        be    = (pass == 0) ? 4'hF : BE_MIX[4*k +: 4];
        mem_model[idx] = merge_lanes(mem_model[idx], wdata, be);
        add_entry(GRP_MEM, 1'b1, word_addr(`MEM_PAGE, idx), be, wdata, '0, 1'b0);
      end
    end
    for (int k = 0; k < 8; k++)
    begin
      idx = (k * 17) % `MEM_WORDS;
      add_entry(GRP_MEM, 1'b0, word_addr(`MEM_PAGE, idx), 4'hF, '0, mem_model[idx], 1'b0);
    end
    // Stray writes aim at live memory words
    add_entry(GRP_ERR, 1'b0, word_addr(16'h4000, 0), 4'hF, '0, `BUS_ERR_DATA, 1'b1);
    add_entry(GRP_ERR, 1'b1, word_addr(16'h4000, 17), 4'hF, lcg_next(), `BUS_ERR_DATA, 1'b1);
    add_entry(GRP_ERR, 1'b1, word_addr(`ROM_PAGE, 34), 4'hF, lcg_next(), `BUS_ERR_DATA, 1'b1);
    add_entry(GRP_ERR, 1'b1, word_addr(16'h8001, 51), 4'hF, lcg_next(), `BUS_ERR_DATA, 1'b1);
    for (int k = 1; k < 4; k++)
      add_entry(GRP_ERR, 1'b0, word_addr(`MEM_PAGE, 17 * k), 4'hF, '0, mem_model[17 * k], 1'b0);
    // Software interrupt set and clear
    ipi_model = 1'b1;
    add_entry(GRP_MSIP, 1'b1, {`CLINT_PAGE, `CLINT_MSIP_OFFS}, 4'hF, 32'h1, '0, 1'b0);
    add_entry(GRP_MSIP, 1'b0, {`CLINT_PAGE, `CLINT_MSIP_OFFS}, 4'hF, '0, 32'h1, 1'b0);
    ipi_model = 1'b0;
    add_entry(GRP_MSIP, 1'b1, {`CLINT_PAGE, `CLINT_MSIP_OFFS}, 4'hF, 32'h0, '0, 1'b0);
    add_entry(GRP_MSIP, 1'b0, {`CLINT_PAGE, `CLINT_MSIP_OFFS}, 4'hF, '0, 32'h0, 1'b0);
  endtask

  //////////////////////////////
  // Handshake driver
  //////////////////////////////

  // Full four-phase transfer with ack timing checked on both edges
  task automatic run_access(input tb_entry_t ent, output logic [31:0] rdata,
                            output logic err);
    bus_req_t nxt;
    int       edges;
    nxt.we        = ent.we;
    nxt.addr.flat = ent.addr;
    nxt.be        = ent.be;
    nxt.wdata     = ent.wdata;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk);
    req     <= 1'b1;
    bus_req <= nxt;
    // First edge samples req so latency is edges minus one
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    while (!ack && edges < ACK_LIMIT);
    if (!ack)
    begin
      errors++;
      $display("No ack_o from the DUT within %0d cycles for address 0x%08h", ACK_LIMIT, ent.addr);
    end
    else
    begin
      compare_value("ack_o latency", edges - 1, 2);
      rdata = bus_rsp.rdata;
      err   = bus_rsp.err;
    end
    @(posedge clk);
    req <= 1'b0;
    edges = 0;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    while (ack && edges < ACK_LIMIT);
    if (ack)
    begin
      errors++;
      $display("ack_o stayed high after req_i dropped, address 0x%08h", ent.addr);
    end
    else
      compare_value("ack_o release edges", edges, 1);
  endtask

  // Watchdog
  initial
  begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", WDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    tb_entry_t   ent;
    logic [31:0] rdata, t_now, cmp;
    logic        err;
    int          grp_errs, cyc;
    req     <= 1'b0;
    bus_req <= '0;
    build_table();

    // Quiet outputs out of reset
    wait (ndmreset_n === 1'b1);
    @(negedge clk);
    grp_errs = errors;
    compare_value("ack_o", 32'(ack), 32'h0);
    compare_value("timer_irq_o", 32'(timer_irq), 32'h0);
    compare_value("ipi_o", 32'(ipi), 32'h0);
    report_test("reset", grp_errs);

    grp_errs = errors;
    for (int i = 0; i < n_entries; i++)
    begin
      ent = table_e[i];
      if (i == 0 || table_e[i-1].grp != ent.grp)
        grp_errs = errors;
      run_access(ent, rdata, err);
      compare_value($sformatf("bus_rsp_o.rdata @0x%08h", ent.addr), rdata, ent.exp_rdata);
      compare_value("bus_rsp_o.err", 32'(err), 32'(ent.exp_err));
      compare_value("ipi_o", 32'(ipi), 32'(ent.exp_ipi));
      if (i == n_entries - 1 || table_e[i+1].grp != ent.grp)
        report_test(group_name(ent.grp), grp_errs);
    end

    // Timer compare 40 ticks ahead
    grp_errs = errors;
    run_access(make_entry(GRP_TIMER, 1'b0, {`CLINT_PAGE, `CLINT_MTIME_OFFS}, 4'hF, '0, '0, 1'b0),
               t_now, err);
    compare_value("bus_rsp_o.err", 32'(err), 32'h0);
    cmp = t_now + 32'd40;
    run_access(make_entry(GRP_TIMER, 1'b1, {`CLINT_PAGE, `CLINT_MTIMECMP_OFFS}, 4'hF, cmp, '0,
                          1'b0), rdata, err);
    compare_value("bus_rsp_o.err", 32'(err), 32'h0);
    compare_value("timer_irq_o", 32'(timer_irq), 32'h0);
    cyc = 0;
    while (!timer_irq && cyc < IRQ_LIMIT)
    begin
      @(negedge clk);
      cyc++;
    end
    if (!timer_irq)
    begin
      errors++;
      $display("timer_irq_o did not rise within %0d cycles", IRQ_LIMIT);
    end
    run_access(make_entry(GRP_TIMER, 1'b0, {`CLINT_PAGE, `CLINT_MTIME_OFFS}, 4'hF, '0, '0, 1'b0),
               t_now, err);
    compare_value("bus_rsp_o.err", 32'(err), 32'h0);
    compare_value("mtime at or past mtimecmp", 32'(t_now >= cmp), 32'h1);
    report_test("timer", grp_errs);

    $display("Summary: %0d tests, %0d with errors, %0d compares, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
logic/soc_bus_pkg.sv
logic/soc_map_pkg.sv
logic/bus_ctrl.sv
logic/boot_rom.sv
logic/main_mem.sv
logic/clint_timer.sv
logic/soc_top.sv
tb/tb_clk_gen.sv
tb/tb_soc_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, status follows the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -j 0 \
  --top-module tb_soc_top -f compile.f

./obj_dir/Vtb_soc_top > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log
then
  exit 0
else
  exit 1
fi
